/* mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_3000

`define NUM_REGS 32

// Return address of jal, past the delay slot
`define LINK_OFFSET 32'd8

`endif

/* mipsIsaPkg.sv */
package mipsIsaPkg;

	// Primary opcodes of the subset
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode;

	// Function field of R-type
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct;

	typedef struct packed {
		opcode      op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct       fn;
	} rFields;

	typedef struct packed {
		opcode       op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFields;

	typedef struct packed {
		opcode       op;
		logic [25:0] index;
	} jFields;

	// One fetched word, three views
	typedef union packed {
		rFields r;
		iFields i;
		jFields j;
	} instrWord;

endpackage

/* mipsCtrlPkg.sv */
package mipsCtrlPkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} aluOp;

	// Next PC source, resolved in decode
	typedef enum logic [1:0] {
		NPC_SEQ,
		NPC_BRANCH,
		NPC_JUMP,
		NPC_JREG
	} npcOp;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_LINK
	} wbSel;

	typedef enum logic [1:0] {
		FWD_RF,  // Value as read or registered
		FWD_E,   // Link of a jal in execute
		FWD_M,   // Memory stage result
		FWD_W    // Writeback data
	} fwdSel;

endpackage

/* hazardCtrl.sv */
`timescale 1ns/1ps

module hazardCtrl (
	input  mipsIsaPkg::instrWord instrD,
	input  mipsIsaPkg::instrWord instrE,
	input  mipsIsaPkg::instrWord instrM,
	input  mipsIsaPkg::instrWord instrW,
	input  logic                 branchTaken,
	output logic                 stall,
	output mipsCtrlPkg::npcOp    npcSel,
	output logic                 extSigned,
	output mipsCtrlPkg::fwdSel   fwdRsD,
	output mipsCtrlPkg::fwdSel   fwdRtD,
	output mipsCtrlPkg::fwdSel   fwdRsE,
	output mipsCtrlPkg::fwdSel   fwdRtE,
	output mipsCtrlPkg::fwdSel   fwdStoreM,
	output mipsCtrlPkg::aluOp    aluSel,
	output logic                 aluImm,
	output logic                 memWrite,
	output mipsCtrlPkg::wbSel    wbChoice,
	output logic                 regWriteW,
	output logic [4:0]           destW
);
	logic [4:0] destE;
	logic [4:0] destM;
	logic       readyE;     // Only a jal has its value in execute
	logic       readyM;     // Load data is not ready until writeback
	logic       isBranchD;
	logic       isJrD;
	logic       useRsD;
	logic       useRtD;
	logic       useRsE;
	logic       useRtE;

	function automatic logic isOp(input mipsIsaPkg::instrWord w, input mipsIsaPkg::opcode op);
		return w.i.op == op;
	endfunction

	function automatic logic isRfn(input mipsIsaPkg::instrWord w, input mipsIsaPkg::funct fn);
		return w.r.op == mipsIsaPkg::OP_RTYPE && w.r.fn == fn;
	endfunction

	// Register written by an instruction, zero if none
	function automatic logic [4:0] destOf(input mipsIsaPkg::instrWord w);
		logic [4:0] d;
		d = 5'd0;
		if (isOp(w, mipsIsaPkg::OP_RTYPE) && !isRfn(w, mipsIsaPkg::FN_JR)) begin
			d = w.r.rd;
		end else if (isOp(w, mipsIsaPkg::OP_ADDIU) || isOp(w, mipsIsaPkg::OP_ORI) ||
				isOp(w, mipsIsaPkg::OP_LUI) || isOp(w, mipsIsaPkg::OP_LW)) begin
			d = w.i.rt;
		end else if (isOp(w, mipsIsaPkg::OP_JAL)) begin
			d = 5'd31;
		end
		return d;
	endfunction

	// Decode read, newest producer wins
	function automatic mipsCtrlPkg::fwdSel fwdDecode(input logic [4:0] src);
		mipsCtrlPkg::fwdSel sel;
		sel = mipsCtrlPkg::FWD_RF;
		if (src == 5'd0) begin
			sel = mipsCtrlPkg::FWD_RF;
		end else if (src == destE) begin
			sel = readyE ? mipsCtrlPkg::FWD_E : mipsCtrlPkg::FWD_RF;
		end else if (src == destM) begin
			sel = readyM ? mipsCtrlPkg::FWD_M : mipsCtrlPkg::FWD_RF;
		end else if (src == destW) begin
			sel = mipsCtrlPkg::FWD_W;
		end
		return sel;
	endfunction

	function automatic mipsCtrlPkg::fwdSel fwdExec(input logic [4:0] src);
		mipsCtrlPkg::fwdSel sel;
		sel = mipsCtrlPkg::FWD_RF;
		if (src == 5'd0) begin
			sel = mipsCtrlPkg::FWD_RF;
		end else if (src == destM) begin
			sel = readyM ? mipsCtrlPkg::FWD_M : mipsCtrlPkg::FWD_RF;   // Store data fixed in memory
		end else if (src == destW) begin
			sel = mipsCtrlPkg::FWD_W;
		end
		return sel;
	endfunction

	// Source needed in decode but still in flight
	function automatic logic blockD(input logic [4:0] src);
		return src != 5'd0 && ((src == destE && !readyE) || (src == destM && !readyM));
	endfunction

	function automatic logic blockE(input logic [4:0] src);
		return src != 5'd0 && src == destE && isOp(instrE, mipsIsaPkg::OP_LW);
	endfunction

	assign destE = destOf(instrE);
	assign destM = destOf(instrM);
	assign destW = destOf(instrW);
	assign regWriteW = destW != 5'd0;
	assign readyE = isOp(instrE, mipsIsaPkg::OP_JAL);
	assign readyM = !isOp(instrM, mipsIsaPkg::OP_LW);

	////////////////////////////////////////
	// Decode stage

	assign isBranchD = isOp(instrD, mipsIsaPkg::OP_BEQ) || isOp(instrD, mipsIsaPkg::OP_BNE);
	assign isJrD = isRfn(instrD, mipsIsaPkg::FN_JR);
	assign useRsD = isBranchD || isJrD;
	assign useRtD = isBranchD;
	assign useRsE = (isOp(instrD, mipsIsaPkg::OP_RTYPE) && !isJrD &&
			!isRfn(instrD, mipsIsaPkg::FN_SLL)) ||
			isOp(instrD, mipsIsaPkg::OP_ADDIU) || isOp(instrD, mipsIsaPkg::OP_ORI) ||
			isOp(instrD, mipsIsaPkg::OP_LW) || isOp(instrD, mipsIsaPkg::OP_SW);
	assign useRtE = isOp(instrD, mipsIsaPkg::OP_RTYPE) && !isJrD;

	always_comb begin
		stall = (useRsD && blockD(instrD.r.rs)) || (useRtD && blockD(instrD.r.rt)) ||
				(useRsE && blockE(instrD.r.rs)) || (useRtE && blockE(instrD.r.rt));
		fwdRsD = fwdDecode(instrD.r.rs);
		fwdRtD = fwdDecode(instrD.r.rt);
	end

	assign npcSel = isBranchD ? (branchTaken ? mipsCtrlPkg::NPC_BRANCH : mipsCtrlPkg::NPC_SEQ) :
			isJrD ? mipsCtrlPkg::NPC_JREG :
			(isOp(instrD, mipsIsaPkg::OP_J) || isOp(instrD, mipsIsaPkg::OP_JAL)) ?
			mipsCtrlPkg::NPC_JUMP : mipsCtrlPkg::NPC_SEQ;
	assign extSigned = !isOp(instrD, mipsIsaPkg::OP_ORI);   // ori zero-extends

	////////////////////////////////////////
	// Execute, memory and writeback

	always_comb begin
		fwdRsE = fwdExec(instrE.r.rs);
		fwdRtE = fwdExec(instrE.r.rt);
		aluSel = mipsCtrlPkg::ALU_ADD;   // addu, addiu and address math
		if (isOp(instrE, mipsIsaPkg::OP_ORI) || isRfn(instrE, mipsIsaPkg::FN_OR)) begin
			aluSel = mipsCtrlPkg::ALU_OR;
		end else if (isOp(instrE, mipsIsaPkg::OP_LUI)) begin
			aluSel = mipsCtrlPkg::ALU_LUI;
		end else if (isRfn(instrE, mipsIsaPkg::FN_SUBU)) begin
			aluSel = mipsCtrlPkg::ALU_SUB;
		end else if (isRfn(instrE, mipsIsaPkg::FN_AND)) begin
			aluSel = mipsCtrlPkg::ALU_AND;
		end else if (isRfn(instrE, mipsIsaPkg::FN_SLT)) begin
			aluSel = mipsCtrlPkg::ALU_SLT;
		end else if (isRfn(instrE, mipsIsaPkg::FN_SLL)) begin
			aluSel = mipsCtrlPkg::ALU_SLL;
		end
	end

	assign aluImm = !isOp(instrE, mipsIsaPkg::OP_RTYPE);
	assign memWrite = isOp(instrM, mipsIsaPkg::OP_SW);
	assign fwdStoreM = (instrM.r.rt != 5'd0 && instrM.r.rt == destW) ?
			mipsCtrlPkg::FWD_W : mipsCtrlPkg::FWD_RF;
	assign wbChoice = isOp(instrW, mipsIsaPkg::OP_LW) ? mipsCtrlPkg::WB_LOAD :
			isOp(instrW, mipsIsaPkg::OP_JAL) ? mipsCtrlPkg::WB_LINK : mipsCtrlPkg::WB_ALU;

endmodule

/* fetchDecode.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module fetchDecode (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [31:0]          instRdata,
	input  logic                 stall,
	input  mipsCtrlPkg::npcOp    npcSel,
	input  logic                 extSigned,
	input  mipsCtrlPkg::fwdSel   fwdRsD,
	input  mipsCtrlPkg::fwdSel   fwdRtD,
	input  logic [31:0]          linkE,
	input  logic [31:0]          resultM,
	input  logic [31:0]          wbData,
	input  logic                 regWriteW,
	input  logic [4:0]           destW,
	output logic [31:0]          instAddr,
	output mipsIsaPkg::instrWord instrD,
	output logic [31:0]          pcD,
	output logic [31:0]          rsValD,
	output logic [31:0]          rtValD,
	output logic [31:0]          immD,
	output logic                 branchTaken
);
	logic [31:0] pcF;
	logic [31:0] npc;
	logic [31:0] regFile [`NUM_REGS];
	logic [31:0] rsRaw;
	logic [31:0] rtRaw;

	////////////////////////////////////////
	// Fetch

	always_ff @(posedge clk) begin
		if (rst) begin
			pcF <= `RESET_PC;
		end else if (!stall) begin
			pcF <= npc;
		end
	end

	assign instAddr = pcF;

	// Targets are relative to the branch in decode
	always_comb begin
		case (npcSel)
			mipsCtrlPkg::NPC_BRANCH: npc = pcD + 32'd4 + {immD[29:0], 2'b00};
			mipsCtrlPkg::NPC_JUMP:   npc = {pcD[31:28], instrD.j.index, 2'b00};
			mipsCtrlPkg::NPC_JREG:   npc = rsValD;
			default:                 npc = pcF + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			instrD <= '0;   // No-op
		end else if (!stall) begin
			instrD <= instRdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pcD <= pcF;
		end
	end

	////////////////////////////////////////
	// Decode

	// $0 stays zero, control never writes it
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regFile[i] <= '0;
			end
		end else if (regWriteW) begin
			regFile[destW] <= wbData;
		end
	end

	assign rsRaw = regFile[instrD.r.rs];
	assign rtRaw = regFile[instrD.r.rt];

	always_comb begin
		case (fwdRsD)
			mipsCtrlPkg::FWD_E: rsValD = linkE;
			mipsCtrlPkg::FWD_M: rsValD = resultM;
			mipsCtrlPkg::FWD_W: rsValD = wbData;
			default:            rsValD = rsRaw;
		endcase
		case (fwdRtD)
			mipsCtrlPkg::FWD_E: rtValD = linkE;
			mipsCtrlPkg::FWD_M: rtValD = resultM;
			mipsCtrlPkg::FWD_W: rtValD = wbData;
			default:            rtValD = rtRaw;
		endcase
	end

	// Compare for beq and bne
	assign branchTaken = (instrD.i.op == mipsIsaPkg::OP_BEQ && rsValD == rtValD) ||
			(instrD.i.op == mipsIsaPkg::OP_BNE && rsValD != rtValD);

	assign immD = extSigned ? {{16{instrD.i.imm[15]}}, instrD.i.imm} : {16'h0000, instrD.i.imm};

endmodule

/* executeStage.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module executeStage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  mipsIsaPkg::instrWord instrD,
	input  logic [31:0]          pcD,
	input  logic [31:0]          rsValD,
	input  logic [31:0]          rtValD,
	input  logic [31:0]          immD,
	input  mipsCtrlPkg::aluOp    aluSel,
	input  logic                 aluImm,
	input  mipsCtrlPkg::fwdSel   fwdRsE,
	input  mipsCtrlPkg::fwdSel   fwdRtE,
	input  logic [31:0]          resultM,
	input  logic [31:0]          wbData,
	output mipsIsaPkg::instrWord instrE,
	output logic [31:0]          pcE,
	output logic [31:0]          linkE,
	output logic [31:0]          aluResE,
	output logic [31:0]          storeValE
);
	logic [31:0] rsValE;
	logic [31:0] rtValE;
	logic [31:0] immE;
	logic [31:0] srcA;
	logic [31:0] srcB;

	// ID/EX, a stall leaves a bubble behind
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			instrE <= '0;
		end else begin
			instrE <= instrD;
		end
	end

	always_ff @(posedge clk) begin
		pcE <= pcD;
		rsValE <= rsValD;
		rtValE <= rtValD;
		immE <= immD;
	end

	assign linkE = pcE + `LINK_OFFSET;

	always_comb begin
		case (fwdRsE)
			mipsCtrlPkg::FWD_M: srcA = resultM;
			mipsCtrlPkg::FWD_W: srcA = wbData;
			default:            srcA = rsValE;
		endcase
		case (fwdRtE)
			mipsCtrlPkg::FWD_M: storeValE = resultM;
			mipsCtrlPkg::FWD_W: storeValE = wbData;
			default:            storeValE = rtValE;
		endcase
	end

	assign srcB = aluImm ? immE : storeValE;

	always_comb begin
		case (aluSel)
			mipsCtrlPkg::ALU_SUB: aluResE = srcA - srcB;
			mipsCtrlPkg::ALU_AND: aluResE = srcA & srcB;
			mipsCtrlPkg::ALU_OR:  aluResE = srcA | srcB;
			mipsCtrlPkg::ALU_SLT: aluResE = {31'd0, $signed(srcA) < $signed(srcB)};
			mipsCtrlPkg::ALU_SLL: aluResE = srcB << instrE.r.shamt;   // Shifts rt
			mipsCtrlPkg::ALU_LUI: aluResE = {immE[15:0], 16'h0000};
			default:              aluResE = srcA + srcB;
		endcase
	end

endmodule

/* memoryStage.sv */
`timescale 1ns/1ps

module memoryStage (
	input  logic                 clk,
	input  logic                 rst,
	input  mipsIsaPkg::instrWord instrE,
	input  logic [31:0]          pcE,
	input  logic [31:0]          linkE,
	input  logic [31:0]          aluResE,
	input  logic [31:0]          storeValE,
	input  logic [31:0]          dataRdata,
	input  logic                 memWrite,
	input  mipsCtrlPkg::fwdSel   fwdStoreM,
	input  mipsCtrlPkg::wbSel    wbChoice,
	output mipsIsaPkg::instrWord instrM,
	output mipsIsaPkg::instrWord instrW,
	output logic [31:0]          resultM,
	output logic [31:0]          dataAddr,
	output logic [31:0]          dataWdata,
	output logic [3:0]           dataByteen,
	output logic [31:0]          wbData,
	output logic [31:0]          wbPc
);
	logic [31:0] pcM;
	logic [31:0] linkM;
	logic [31:0] aluResM;
	logic [31:0] storeValM;
	logic [31:0] aluResW;
	logic [31:0] loadW;
	logic [31:0] linkW;

	////////////////////////////////////////
	// EX/MEM and data memory side

	always_ff @(posedge clk) begin
		if (rst) begin
			instrM <= '0;
		end else begin
			instrM <= instrE;
		end
	end

	always_ff @(posedge clk) begin
		pcM <= pcE;
		linkM <= linkE;
		aluResM <= aluResE;
		storeValM <= storeValE;
	end

	// Forwardable value, jal carries its link
	assign resultM = (instrM.j.op == mipsIsaPkg::OP_JAL) ? linkM : aluResM;

	assign dataAddr = aluResM;
	assign dataWdata = (fwdStoreM == mipsCtrlPkg::FWD_W) ? wbData : storeValM;
	assign dataByteen = memWrite ? 4'b1111 : 4'b0000;   // Word stores only

	////////////////////////////////////////
	// MEM/WB

	always_ff @(posedge clk) begin
		if (rst) begin
			instrW <= '0;
		end else begin
			instrW <= instrM;
		end
	end

	always_ff @(posedge clk) begin
		wbPc <= pcM;
		aluResW <= aluResM;
		loadW <= dataRdata;
		linkW <= linkM;
	end

	always_comb begin
		case (wbChoice)
			mipsCtrlPkg::WB_LOAD: wbData = loadW;
			mipsCtrlPkg::WB_LINK: wbData = linkW;
			default:              wbData = aluResW;
		endcase
	end

endmodule

/* mips.sv */
`timescale 1ns/1ps

module mips (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] instRdata,
	input  logic [31:0] dataRdata,
	output logic [31:0] instAddr,
	output logic [31:0] dataAddr,
	output logic [31:0] dataWdata,
	output logic [3:0]  dataByteen,
	output logic        grfWe,
	output logic [4:0]  grfAddr,
	output logic [31:0] grfWdata,
	output logic [31:0] wbPc
);
	// Stage instruction words
	mipsIsaPkg::instrWord instrD;
	mipsIsaPkg::instrWord instrE;
	mipsIsaPkg::instrWord instrM;
	mipsIsaPkg::instrWord instrW;

	// Control from hazardCtrl
	logic               stall;
	logic               branchTaken;
	mipsCtrlPkg::npcOp  npcSel;
	logic               extSigned;
	mipsCtrlPkg::fwdSel fwdRsD;
	mipsCtrlPkg::fwdSel fwdRtD;
	mipsCtrlPkg::fwdSel fwdRsE;
	mipsCtrlPkg::fwdSel fwdRtE;
	mipsCtrlPkg::fwdSel fwdStoreM;
	mipsCtrlPkg::aluOp  aluSel;
	logic               aluImm;
	logic               memWrite;
	mipsCtrlPkg::wbSel  wbChoice;

	// Datapath between stages
	logic [31:0] pcD;
	logic [31:0] rsValD;
	logic [31:0] rtValD;
	logic [31:0] immD;
	logic [31:0] pcE;
	logic [31:0] linkE;
	logic [31:0] aluResE;
	logic [31:0] storeValE;
	logic [31:0] resultM;

	hazardCtrl u_ctrl (.*, .regWriteW(grfWe), .destW(grfAddr));

	fetchDecode u_fetch (.*, .regWriteW(grfWe), .destW(grfAddr), .wbData(grfWdata));

	executeStage u_exec (.*, .wbData(grfWdata));

	memoryStage u_mem (.*, .wbData(grfWdata));   // Writeback data is the trace value

endmodule

/* mips_asserts.sv */
`timescale 1ns/1ps

module mipsAsserts (
	input logic        clk,
	input logic        rst,
	input logic [3:0]  dataByteen,
	input logic [31:0] dataAddr,
	input logic [31:0] instrD,
	input logic [31:0] rsValD,
	input logic        stall
);

	// Register 0 reads as zero in decode
	zeroReg: assert property (@(posedge clk) disable iff (rst)
			instrD[25:21] == 5'd0 |-> rsValD == 32'd0)
		else $error("register 0 read as %h in decode", rsValD);

	wordStore: assert property (@(posedge clk) disable iff (rst)
			dataByteen != 4'b0000 |-> dataAddr[1:0] == 2'b00)
		else $error("store to unaligned address %h", dataAddr);

	// Interlock clears within two cycles
	stallBound: assert property (@(posedge clk) disable iff (rst)
			stall && $past(stall) |-> !$past(stall, 2))
		else $error("stall held for more than two cycles");

endmodule

bind mips mipsAsserts u_asserts (
	.clk(clk),
	.rst(rst),
	.dataByteen(dataByteen),
	.dataAddr(dataAddr),
	.instrD(instrD),
	.rsValD(rsValD),
	.stall(stall)
);

/* mipsChecker.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module mipsChecker (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] instAddr,
	input  logic [3:0]  dataByteen,
	input  logic        grfWe,
	input  logic [4:0]  grfAddr,
	input  logic [31:0] grfWdata,
	input  logic [31:0] wbPc,
	output logic        done,
	output int          errors,
	output int          checked
);
	logic [31:0] mem [256];
	int          base;      // First record word
	int          numExp;
	logic        wasRst;

	initial begin
		errors = 0;
		checked = 0;
		done = 1'b0;
		wasRst = 1'b1;
		for (int i = 0; i < 256; i++) begin
			mem[i] = '0;
		end
		$readmemh("mips_testdata.mem", mem);
		base = 0;
		while (base < 255 && mem[base] !== 32'hdead_beef) begin
			base++;
		end
		base++;
		numExp = (256 - base) / 3;
		// Records end at the first pc of zero
		for (int k = 0; k < (256 - base) / 3; k++) begin
			if (mem[base + 3 * k] == 32'd0 && numExp == (256 - base) / 3) begin
				numExp = k;
			end
		end
		if (numExp == 0) begin
			$display("No expected records found in the data file");
			errors = 1;
		end
	end

	always @(posedge clk) begin
		wasRst <= rst;
		if (rst) begin
			if (grfWe || dataByteen != 4'b0000) begin
				$display("ERROR at %0t: writeback or store during reset", $time);
				errors <= errors + 1;
			end
		end else begin
			if (wasRst && instAddr != `RESET_PC) begin   // First fetch after reset
				$display("ERROR at %0t: first fetch at %h, expected %h", $time, instAddr,
						`RESET_PC);
				errors <= errors + 1;
			end
			if (grfWe) begin
				if (checked >= numExp) begin
					$display("ERROR at %0t: extra writeback pc %h reg %0d", $time, wbPc, grfAddr);
					errors <= errors + 1;
				end else if (wbPc != mem[base + 3 * checked] ||
						{27'd0, grfAddr} != mem[base + 3 * checked + 1] ||
						grfWdata != mem[base + 3 * checked + 2]) begin
					$display("ERROR at %0t: writeback pc %h reg %0d value %h, expected %h %0d %h",
							$time, wbPc, grfAddr, grfWdata, mem[base + 3 * checked],
							mem[base + 3 * checked + 1], mem[base + 3 * checked + 2]);
					errors <= errors + 1;
				end
				checked <= checked + 1;
				if (checked + 1 >= numExp) begin
					done <= 1'b1;
				end
			end
		end
	end

endmodule

/* tbMips.sv */
`timescale 1ns/1ps
`include "mips_params.svh"

module tbMips;
	logic        clk;
	logic        rst;
	logic [31:0] instRdata;
	logic [31:0] dataRdata;
	logic [31:0] instAddr;
	logic [31:0] dataAddr;
	logic [31:0] dataWdata;
	logic [3:0]  dataByteen;
	logic        grfWe;
	logic [4:0]  grfAddr;
	logic [31:0] grfWdata;
	logic [31:0] wbPc;
	logic        done;
	int          errors;
	int          checked;
	int          cycles;
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] instOffs;

	mips u_dut (.*);

	mipsChecker u_check (.*);

	////////////////////////////////////////
	// Clock and memories

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	initial begin
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = 32'ha5a5_0000 ^ i;
		end
		$readmemh("mips_testdata.mem", imem);
	end

	assign instOffs = instAddr - `RESET_PC;
	assign instRdata = (instOffs < 32'd1024) ? imem[instOffs[9:2]] : 32'd0;   // Same cycle
	assign dataRdata = dmem[dataAddr[9:2]];

	always @(posedge clk) begin
		if (|dataByteen) begin
			dmem[dataAddr[9:2]] <= dataWdata;
		end
	end

	////////////////////////////////////////
	// Run control

	initial begin
		rst = 1'b1;
		cycles = 0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		while (!done && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("Timeout: the expected writebacks did not all appear within 2000 cycles");
		end
		$display("Writebacks checked: %0d, errors: %0d", checked, errors);
		if (done && errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* mips_testdata.mem */
// Program words from RESET_PC, then marker deadbeef
// Then expected writebacks, one per line: pc reg value
34011234 3c02abcd 00221821 00612023
00642824 00243025 0081382a 00014100
2509ffff ac090010 8c0a0010 01415821
116a0003 240c0005 15800002 240d0007
240e0063 0c000c18 240f0001 08000c1c
24100002 00000000 00000000 00000000
03e00008 24110003 00000000 00000000
1000ffff 00000000
deadbeef
00003000 00000001 00001234
00003004 00000002 abcd0000
00003008 00000003 abcd1234
0000300c 00000004 abcd0000
00003010 00000005 abcd0000
00003014 00000006 abcd1234
00003018 00000007 00000001
0000301c 00000008 00012340
00003020 00000009 0001233f
00003028 0000000a 0001233f
0000302c 0000000b 00013573
00003034 0000000c 00000005
0000303c 0000000d 00000007
00003044 0000001f 0000304c
00003048 0000000f 00000001
00003064 00000011 00000003
00003050 00000010 00000002

/* flist.f */
+incdir+.
mipsIsaPkg.sv
mipsCtrlPkg.sv
hazardCtrl.sv
fetchDecode.sv
executeStage.sv
memoryStage.sv
mips.sv
mips_asserts.sv
mipsChecker.sv
tbMips.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tbMips
FLIST     = flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
